// ==== rv_shell_params.svh ====
////////////////////////////////////////////////////////////////////////////
// Core shell parameters
// Widths and depths of the register file, cache RAMs and scramble key,
// plus the key and nonce loaded at reset
////////////////////////////////////////////////////////////////////////////

`ifndef RV_SHELL_PARAMS_SVH
`define RV_SHELL_PARAMS_SVH

// Data path
`define XLEN        32
`define RF_ADDR_W   5

// Instruction cache geometry, 64 lines per way
`define IC_NUM_WAYS 2
`define IC_INDEX_W  6
`define IC_TAG_W    22
`define IC_LINE_W   64

// Scramble key and nonce
`define SCR_KEY_W   128
`define SCR_NONCE_W 64

// Values held until the first key arrives
`define SCR_KEY_RST   128'h3c7a_91d2_e465_0b8f_7d21_c4a9_56e0_13bf
`define SCR_NONCE_RST 64'h9e37_79b9_7f4a_7c15

`endif

// ==== rv_shell_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Core shell package
// Shared word, address, tag, line and key types
////////////////////////////////////////////////////////////////////////////

`include "rv_shell_params.svh"

package rv_shell_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`XLEN-1:0]      word_t;
  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction cache RAMs
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`IC_INDEX_W-1:0]  ic_index_t;
  typedef logic [`IC_TAG_W-1:0]    ic_tag_t;
  typedef logic [`IC_LINE_W-1:0]   ic_line_t;
  // One request bit per way
  typedef logic [`IC_NUM_WAYS-1:0] ic_way_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Scrambling
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [`SCR_NONCE_W-1:0] scr_nonce_t;

endpackage

// ==== rv_clock_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Core clock control
// Registers the busy flag, combines it with the wake sources and gates
// the core clock through an enable latch
////////////////////////////////////////////////////////////////////////////

module rv_clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;
  logic en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Wake sources act without waiting for an edge
  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////////////////////

  // Enable sampled in the low phase, stable across the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch <= clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latch;

endmodule

// ==== rv_register_file.sv ====
////////////////////////////////////////////////////////////////////////////
// Register file
// 31 flip-flop registers, two combinational read ports and one write
// port, clocked by the gated core clock
////////////////////////////////////////////////////////////////////////////

`include "rv_shell_params.svh"

module rv_register_file (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  rv_shell_pkg::rf_addr_t rf_raddr_a_i,
  input  rv_shell_pkg::rf_addr_t rf_raddr_b_i,
  input  rv_shell_pkg::rf_addr_t rf_waddr_i,
  input  rv_shell_pkg::word_t    rf_wdata_i,
  input  logic                   rf_we_i,
  output rv_shell_pkg::word_t    rf_rdata_a_o,
  output rv_shell_pkg::word_t    rf_rdata_b_o
);

  import rv_shell_pkg::*;

  localparam int unsigned NumRegs = 1 << `RF_ADDR_W;

  logic [NumRegs-1:1] we_dec;
  word_t              rf_q    [NumRegs-1:1];
  word_t              rf_full [NumRegs];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // x0 has no storage, so address 0 never enables a register
  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = rf_we_i & (rf_waddr_i == rf_addr_t'(i));
    end
  end

  for (genvar r = 1; r < NumRegs; r++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[r] <= '0;
      end else if (we_dec[r]) begin
        rf_q[r] <= rf_wdata_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rf_full[0] = '0;
    for (int unsigned i = 1; i < NumRegs; i++) begin
      rf_full[i] = rf_q[i];
    end
  end

  assign rf_rdata_a_o = rf_full[rf_raddr_a_i];
  assign rf_rdata_b_o = rf_full[rf_raddr_b_i];

  // A glitch on the write address could open two registers at once
  rf_we_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(we_dec)
  ) else $error("register file write enables not one-hot");

endmodule

// ==== rv_scramble_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Scramble key control
// Requests a new key after a cache invalidation and holds the current
// key and nonce for the cache RAMs
////////////////////////////////////////////////////////////////////////////

`include "rv_shell_params.svh"

module rv_scramble_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     icache_inval_i,
  input  logic                     scramble_key_valid_i,
  input  rv_shell_pkg::scr_key_t   scramble_key_i,
  input  rv_shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                     scramble_req_o,
  output logic                     key_valid_o,
  output rv_shell_pkg::scr_key_t   key_o,
  output rv_shell_pkg::scr_nonce_t nonce_o
);

  import rv_shell_pkg::*;

  logic       req_d, req_q;
  logic       key_valid_d, key_valid_q;
  scr_key_t   key_q;
  scr_nonce_t nonce_q;

  // Request held until the key source answers
  assign req_d       = req_q ? ~scramble_key_valid_i : icache_inval_i;
  assign key_valid_d = req_q          ? scramble_key_valid_i :
                       icache_inval_i ? 1'b0                 :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= `SCR_KEY_RST;
      nonce_q <= `SCR_NONCE_RST;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

  scr_req_excl_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(scramble_req_o && key_valid_o)
  ) else $error("key request pending while key marked valid");

endmodule

// ==== rv_icache_rams.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction cache RAMs
// One tag bank and one data bank per way, single port with registered
// read, contents masked by the current scramble keystream
////////////////////////////////////////////////////////////////////////////

`include "rv_shell_params.svh"

module rv_icache_rams (
  input  logic                         clk_i,
  input  rv_shell_pkg::scr_key_t       key_i,
  input  rv_shell_pkg::scr_nonce_t     nonce_i,
  input  rv_shell_pkg::ic_way_mask_t   ic_tag_req_i,
  input  logic                         ic_tag_write_i,
  input  rv_shell_pkg::ic_index_t      ic_tag_addr_i,
  input  rv_shell_pkg::ic_tag_t        ic_tag_wdata_i,
  input  rv_shell_pkg::ic_way_mask_t   ic_data_req_i,
  input  logic                         ic_data_write_i,
  input  rv_shell_pkg::ic_index_t      ic_data_addr_i,
  input  rv_shell_pkg::ic_line_t       ic_data_wdata_i,
  output rv_shell_pkg::ic_tag_t        ic_tag_rdata_o  [`IC_NUM_WAYS],
  output rv_shell_pkg::ic_line_t       ic_data_rdata_o [`IC_NUM_WAYS]
);

  import rv_shell_pkg::*;

  localparam int unsigned NumLines = 1 << `IC_INDEX_W;

  ic_tag_t  tag_ks;
  ic_line_t data_ks;

  // Tags use the low key bits, lines the nonce
  assign tag_ks  = key_i[`IC_TAG_W-1:0];
  assign data_ks = nonce_i;

  for (genvar w = 0; w < `IC_NUM_WAYS; w++) begin : gen_ways
    ic_tag_t  tag_mem  [NumLines];
    ic_line_t data_mem [NumLines];
    ic_tag_t  tag_rdata_q;
    ic_line_t data_rdata_q;

    // Tag bank
    always_ff @(posedge clk_i) begin
      if (ic_tag_req_i[w]) begin
        if (ic_tag_write_i) begin
          tag_mem[ic_tag_addr_i] <= ic_tag_wdata_i ^ tag_ks;
        end else begin
          tag_rdata_q <= tag_mem[ic_tag_addr_i] ^ tag_ks;
        end
      end
    end

    // Data bank
    always_ff @(posedge clk_i) begin
      if (ic_data_req_i[w]) begin
        if (ic_data_write_i) begin
          data_mem[ic_data_addr_i] <= ic_data_wdata_i ^ data_ks;
        end else begin
          data_rdata_q <= data_mem[ic_data_addr_i] ^ data_ks;
        end
      end
    end

    assign ic_tag_rdata_o[w]  = tag_rdata_q;
    assign ic_data_rdata_o[w] = data_rdata_q;
  end

endmodule

// ==== rv_core_shell.sv ====
////////////////////////////////////////////////////////////////////////////
// Core infrastructure shell
// Clock gating, register file, scramble key control and instruction
// cache RAMs around an external RISC-V core
////////////////////////////////////////////////////////////////////////////

`include "rv_shell_params.svh"

module rv_core_shell (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       test_en_i,
  // Clock control
  input  logic                       core_busy_i,
  input  logic                       debug_req_i,
  input  logic                       irq_pending_i,
  input  logic                       irq_nm_i,
  output logic                       core_sleep_o,
  // Register file
  input  rv_shell_pkg::rf_addr_t     rf_raddr_a_i,
  input  rv_shell_pkg::rf_addr_t     rf_raddr_b_i,
  input  rv_shell_pkg::rf_addr_t     rf_waddr_i,
  input  rv_shell_pkg::word_t        rf_wdata_i,
  input  logic                       rf_we_i,
  output rv_shell_pkg::word_t        rf_rdata_a_o,
  output rv_shell_pkg::word_t        rf_rdata_b_o,
  // Scrambling
  input  logic                       icache_inval_i,
  input  logic                       scramble_key_valid_i,
  input  rv_shell_pkg::scr_key_t     scramble_key_i,
  input  rv_shell_pkg::scr_nonce_t   scramble_nonce_i,
  output logic                       scramble_req_o,
  output logic                       ic_scr_key_valid_o,
  // Cache RAMs
  input  rv_shell_pkg::ic_way_mask_t ic_tag_req_i,
  input  logic                       ic_tag_write_i,
  input  rv_shell_pkg::ic_index_t    ic_tag_addr_i,
  input  rv_shell_pkg::ic_tag_t      ic_tag_wdata_i,
  output rv_shell_pkg::ic_tag_t      ic_tag_rdata_o  [`IC_NUM_WAYS],
  input  rv_shell_pkg::ic_way_mask_t ic_data_req_i,
  input  logic                       ic_data_write_i,
  input  rv_shell_pkg::ic_index_t    ic_data_addr_i,
  input  rv_shell_pkg::ic_line_t     ic_data_wdata_i,
  output rv_shell_pkg::ic_line_t     ic_data_rdata_o [`IC_NUM_WAYS]
);

  import rv_shell_pkg::*;

  logic       clk_gated;
  scr_key_t   scr_key;
  scr_nonce_t scr_nonce;

  rv_clock_ctrl u_clock_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .core_busy_i   (core_busy_i),
    .debug_req_i   (debug_req_i),
    .irq_pending_i (irq_pending_i),
    .irq_nm_i      (irq_nm_i),
    .clk_gated_o   (clk_gated),
    .core_sleep_o  (core_sleep_o)
  );

  // Register file only sees edges while the core is awake
  rv_register_file u_register_file (
    .clk_i        (clk_gated),
    .rst_ni       (rst_ni),
    .rf_raddr_a_i (rf_raddr_a_i),
    .rf_raddr_b_i (rf_raddr_b_i),
    .rf_waddr_i   (rf_waddr_i),
    .rf_wdata_i   (rf_wdata_i),
    .rf_we_i      (rf_we_i),
    .rf_rdata_a_o (rf_rdata_a_o),
    .rf_rdata_b_o (rf_rdata_b_o)
  );

  rv_scramble_ctrl u_scramble_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .icache_inval_i       (icache_inval_i),
    .scramble_key_valid_i (scramble_key_valid_i),
    .scramble_key_i       (scramble_key_i),
    .scramble_nonce_i     (scramble_nonce_i),
    .scramble_req_o       (scramble_req_o),
    .key_valid_o          (ic_scr_key_valid_o),
    .key_o                (scr_key),
    .nonce_o              (scr_nonce)
  );

  rv_icache_rams u_icache_rams (
    .clk_i           (clk_i),
    .key_i           (scr_key),
    .nonce_i         (scr_nonce),
    .ic_tag_req_i    (ic_tag_req_i),
    .ic_tag_write_i  (ic_tag_write_i),
    .ic_tag_addr_i   (ic_tag_addr_i),
    .ic_tag_wdata_i  (ic_tag_wdata_i),
    .ic_data_req_i   (ic_data_req_i),
    .ic_data_write_i (ic_data_write_i),
    .ic_data_addr_i  (ic_data_addr_i),
    .ic_data_wdata_i (ic_data_wdata_i),
    .ic_tag_rdata_o  (ic_tag_rdata_o),
    .ic_data_rdata_o (ic_data_rdata_o)
  );

  // Cache must stay idle while the key is being renewed
  ic_no_req_without_key : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !ic_scr_key_valid_o |-> !(|ic_tag_req_i) && !(|ic_data_req_i)
  ) else $error("cache RAM request while scramble key invalid");

endmodule

// ==== tb_rv_core_shell.sv ====
////////////////////////////////////////////////////////////////////////////
// Core shell testbench
// Directed tests for sleep control, register file, cache RAMs and the
// scramble key renewal, with the testbench acting as the core
////////////////////////////////////////////////////////////////////////////

`include "rv_shell_params.svh"

module tb_rv_core_shell;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_shell_pkg::*;

  localparam int ClkPeriod     = 100;
  localparam int NumTests      = 5;
  localparam int MaxTestCycles = 100;
  localparam int MarginCycles  = 50;
  localparam int TimeoutNs     = (NumTests * MaxTestCycles + MarginCycles) * ClkPeriod;

  localparam scr_key_t   KeyRst   = `SCR_KEY_RST;
  localparam scr_nonce_t NonceRst = `SCR_NONCE_RST;

  logic         clk_i, rst_ni, test_en_i;
  logic         core_busy_i, debug_req_i, irq_pending_i, irq_nm_i, core_sleep_o;
  rf_addr_t     rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  word_t        rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic         rf_we_i;
  logic         icache_inval_i, scramble_key_valid_i, scramble_req_o, ic_scr_key_valid_o;
  scr_key_t     scramble_key_i;
  scr_nonce_t   scramble_nonce_i;
  ic_way_mask_t ic_tag_req_i, ic_data_req_i;
  logic         ic_tag_write_i, ic_data_write_i;
  ic_index_t    ic_tag_addr_i, ic_data_addr_i;
  ic_tag_t      ic_tag_wdata_i;
  ic_line_t     ic_data_wdata_i;
  ic_tag_t      ic_tag_rdata_o  [`IC_NUM_WAYS];
  ic_line_t     ic_data_rdata_o [`IC_NUM_WAYS];

  int          errors    = 0;
  int          checks    = 0;
  logic [31:0] rng_state = 32'h4c25_721b;

  // Reference contents as written by the core
  word_t     rf_model   [32];
  ic_tag_t   tag_model  [`IC_NUM_WAYS][64];
  ic_line_t  line_model [`IC_NUM_WAYS][64];
  ic_index_t written_idx[$];

  rv_core_shell i_rv_core_shell (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired: tests did not finish within %0d ns", TimeoutNs);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Inputs change 10 ns after the rising edge
  task automatic next_drive_point();
    @(posedge clk_i);
    #10;
  endtask

  task automatic settle();
    #20;
  endtask

  task automatic cache_write_both(input ic_index_t idx);
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      ic_tag_req_i    = ic_way_mask_t'(1 << w);
      ic_data_req_i   = ic_way_mask_t'(1 << w);
      ic_tag_write_i  = 1'b1;
      ic_data_write_i = 1'b1;
      ic_tag_addr_i   = idx;
      ic_data_addr_i  = idx;
      ic_tag_wdata_i  = ic_tag_t'(next_random());
      ic_data_wdata_i = {next_random(), next_random()};
      tag_model[w][idx]  = ic_tag_wdata_i;
      line_model[w][idx] = ic_data_wdata_i;
      next_drive_point();
    end
    ic_tag_req_i    = '0;
    ic_data_req_i   = '0;
    ic_tag_write_i  = 1'b0;
    ic_data_write_i = 1'b0;
  endtask

  // Reads both ways at once
  // Masks carry the expected keystream change
  task automatic cache_read_check(input ic_index_t idx, input ic_tag_t tag_mask,
                                  input ic_line_t line_mask);
    ic_tag_req_i   = '1;
    ic_data_req_i  = '1;
    ic_tag_addr_i  = idx;
    ic_data_addr_i = idx;
    next_drive_point();
    ic_tag_req_i  = '0;
    ic_data_req_i = '0;
    settle();
    for (int w = 0; w < `IC_NUM_WAYS; w++) begin
      compare($sformatf("way %0d tag at %0d", w, idx), 128'(ic_tag_rdata_o[w]),
              128'(tag_model[w][idx] ^ tag_mask));
      compare($sformatf("way %0d line at %0d", w, idx), 128'(ic_data_rdata_o[w]),
              128'(line_model[w][idx] ^ line_mask));
    end
    next_drive_point();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic after_reset_state();
    settle();
    compare("core_sleep_o", 128'(core_sleep_o), 128'(1'b1));
    compare("scramble_req_o", 128'(scramble_req_o), 128'(1'b0));
    compare("ic_scr_key_valid_o", 128'(ic_scr_key_valid_o), 128'(1'b1));
    for (int r = 0; r < 32; r++) begin
      rf_raddr_a_i = rf_addr_t'(r);
      rf_raddr_b_i = rf_addr_t'(31 - r);
      settle();
      compare($sformatf("port a reg %0d", r), 128'(rf_rdata_a_o), 128'(0));
      compare($sformatf("port b reg %0d", 31 - r), 128'(rf_rdata_b_o), 128'(0));
      next_drive_point();
    end
  endtask

  task automatic sleep_and_wake();
    core_busy_i = 1'b1;
    settle();
    compare("sleep before busy edge", 128'(core_sleep_o), 128'(1'b1));
    next_drive_point();
    settle();
    compare("sleep after busy edge", 128'(core_sleep_o), 128'(1'b0));
    next_drive_point();
    core_busy_i = 1'b0;
    settle();
    compare("sleep before idle edge", 128'(core_sleep_o), 128'(1'b0));
    next_drive_point();
    settle();
    compare("sleep after idle edge", 128'(core_sleep_o), 128'(1'b1));
    next_drive_point();
    for (int s = 0; s < 3; s++) begin
      case (s)
        0:       irq_pending_i = 1'b1;
        1:       irq_nm_i      = 1'b1;
        default: debug_req_i   = 1'b1;
      endcase
      settle();
      compare($sformatf("sleep with wake source %0d", s), 128'(core_sleep_o), 128'(1'b0));
      next_drive_point();
      {irq_pending_i, irq_nm_i, debug_req_i} = 3'b000;
      settle();
      compare($sformatf("sleep after wake source %0d", s), 128'(core_sleep_o), 128'(1'b1));
      next_drive_point();
    end
  endtask

  task automatic register_file_rw();
    core_busy_i = 1'b1;
    // Busy flag and clock gate each take one edge
    repeat (2) next_drive_point();
    for (int r = 1; r < 32; r++) begin
      rf_we_i    = 1'b1;
      rf_waddr_i = rf_addr_t'(r);
      rf_wdata_i = next_random();
      rf_model[r] = rf_wdata_i;
      next_drive_point();
    end
    rf_we_i = 1'b0;
    for (int r = 1; r < 32; r++) begin
      rf_raddr_a_i = rf_addr_t'(r);
      rf_raddr_b_i = rf_addr_t'(32 - r);
      settle();
      compare($sformatf("port a reg %0d", r), 128'(rf_rdata_a_o), 128'(rf_model[r]));
      compare($sformatf("port b reg %0d", 32 - r), 128'(rf_rdata_b_o), 128'(rf_model[32 - r]));
      next_drive_point();
    end
    rf_we_i    = 1'b1;
    rf_waddr_i = '0;
    rf_wdata_i = next_random();
    next_drive_point();
    rf_we_i      = 1'b0;
    rf_raddr_a_i = '0;
    settle();
    compare("reg 0 after write", 128'(rf_rdata_a_o), 128'(0));
    next_drive_point();
    core_busy_i = 1'b0;
    next_drive_point();
    // Asleep now and this write meets no gated edge
    rf_we_i    = 1'b1;
    rf_waddr_i = rf_addr_t'(7);
    rf_wdata_i = ~rf_model[7];
    settle();
    compare("sleep during lost write", 128'(core_sleep_o), 128'(1'b1));
    next_drive_point();
    rf_we_i      = 1'b0;
    rf_raddr_a_i = rf_addr_t'(7);
    settle();
    compare("reg 7 after sleeping write", 128'(rf_rdata_a_o), 128'(rf_model[7]));
    next_drive_point();
  endtask

  task automatic cache_ram_rw();
    ic_index_t idx;
    written_idx.delete();
    for (int i = 0; i < 8; i++) begin
      idx = ic_index_t'(next_random());
      written_idx.push_back(idx);
      cache_write_both(idx);
    end
    foreach (written_idx[i]) cache_read_check(written_idx[i], '0, '0);
  endtask

  task automatic key_renewal();
    ic_index_t  idx;
    scr_key_t   new_key;
    scr_nonce_t new_nonce;
    int         wait_cycles;
    written_idx.delete();
    for (int i = 0; i < 4; i++) begin
      idx = ic_index_t'(next_random());
      written_idx.push_back(idx);
      cache_write_both(idx);
    end
    icache_inval_i = 1'b1;
    next_drive_point();
    icache_inval_i = 1'b0;
    wait_cycles    = int'(next_random() & 32'h7);
    for (int c = 0; c <= wait_cycles; c++) begin
      settle();
      compare($sformatf("scramble_req_o wait %0d", c), 128'(scramble_req_o), 128'(1'b1));
      compare($sformatf("key valid wait %0d", c), 128'(ic_scr_key_valid_o), 128'(1'b0));
      if (c < wait_cycles) next_drive_point();
    end
    new_key   = {next_random(), next_random(), next_random(), next_random()};
    new_nonce = {next_random(), next_random()};
    next_drive_point();
    scramble_key_i       = new_key;
    scramble_nonce_i     = new_nonce;
    scramble_key_valid_i = 1'b1;
    next_drive_point();
    scramble_key_valid_i = 1'b0;
    settle();
    compare("scramble_req_o after key", 128'(scramble_req_o), 128'(1'b0));
    compare("key valid after key", 128'(ic_scr_key_valid_o), 128'(1'b1));
    next_drive_point();
    foreach (written_idx[i]) begin
      cache_read_check(written_idx[i], KeyRst[`IC_TAG_W-1:0] ^ new_key[`IC_TAG_W-1:0],
                       NonceRst ^ new_nonce);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni               = 1'b0;
    test_en_i            = 1'b0;
    core_busy_i          = 1'b0;
    debug_req_i          = 1'b0;
    irq_pending_i        = 1'b0;
    irq_nm_i             = 1'b0;
    rf_raddr_a_i         = '0;
    rf_raddr_b_i         = '0;
    rf_waddr_i           = '0;
    rf_wdata_i           = '0;
    rf_we_i              = 1'b0;
    icache_inval_i       = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    ic_tag_req_i         = '0;
    ic_tag_write_i       = 1'b0;
    ic_tag_addr_i        = '0;
    ic_tag_wdata_i       = '0;
    ic_data_req_i        = '0;
    ic_data_write_i      = 1'b0;
    ic_data_addr_i       = '0;
    ic_data_wdata_i      = '0;
    repeat (2) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    after_reset_state();
    sleep_and_wake();
    register_file_rw();
    cache_ram_rw();
    key_renewal();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== rv_core_shell.f ====
+incdir+.
rv_shell_pkg.sv
rv_clock_ctrl.sv
rv_register_file.sv
rv_scramble_ctrl.sv
rv_icache_rams.sv
rv_core_shell.sv
tb_rv_core_shell.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the core shell testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_rv_core_shell

if ! verilator --binary --timing --assert --top-module "$TOP" \
    -f rv_core_shell.f -o "V$TOP"; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
